/* rtl/rrack_pkg.sv */
`default_nettype none

package rrack_pkg;

  localparam int AXIS_DATA_W = 512;
  localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;

  typedef logic [AXIS_DATA_W-1:0] axis_data_t;
  typedef logic [AXIS_KEEP_W-1:0] axis_keep_t;
  typedef logic [23:0] psn_t;
  typedef logic [23:0] qpn_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [8:0]  pkt_len_t;

  localparam int       NUM_QP                = 5;
  localparam qpn_t     FIRST_QP              = 24'd3;
  localparam int       QP_IDX_W              = $clog2(NUM_QP);
  localparam int       HDR_BYTES             = 58; // eth + ipv4 + udp + bth + aeth
  localparam int       IP_HDR_BYTES          = 20;
  localparam int       RD_RESP_PAYLOAD_BYTES = 256;
  localparam pkt_len_t RD_RESP_LEN           = 9'd314;
  localparam pkt_len_t ACK_LEN               = 9'd58;
  localparam int       PKT_IMG_BYTES         = 320; // five full beats
  localparam int       NUM_RD_RESP           = 8;
  localparam int       NUM_WR_ACK            = 8;
  localparam int       IFG_CYCLES            = 256;
  localparam int       IFG_CNT_W             = $clog2(IFG_CYCLES);

  typedef logic [HDR_BYTES*8-1:0] roce_hdr_t; // wire byte 0 in [7:0]
  typedef logic [IFG_CNT_W-1:0]   ifg_cnt_t;

  localparam logic [7:0] OPC_RD_RESP = 8'h10; // read response only
  localparam logic [7:0] OPC_ACK     = 8'h11;

  // msb byte offsets of the request descriptor fields
  localparam int REQ_QPN_BYTE = 47;
  localparam int REQ_PSN_BYTE = 51;

  localparam logic [15:0] ETH_TYPE_IPV4   = 16'h0800;
  localparam logic [7:0]  IP_VER_IHL      = 8'h45;
  localparam logic [7:0]  IP_TOS          = 8'hb8;
  localparam logic [15:0] IP_ID           = 16'h5555;
  localparam logic [15:0] IP_FLAGS        = 16'h4000; // don't fragment
  localparam logic [7:0]  IP_TTL          = 8'hba;
  localparam logic [7:0]  IP_PROTO_UDP    = 8'h11;
  localparam logic [15:0] IP_TOT_LEN_RD   = 16'h0130;
  localparam logic [15:0] IP_TOT_LEN_ACK  = 16'h0030;
  localparam logic [15:0] UDP_SRC_PORT    = 16'h6851;
  localparam logic [15:0] UDP_DST_PORT    = 16'h12b7; // rocev2
  localparam logic [7:0]  BTH_FLAGS       = 8'h00;
  localparam logic [15:0] BTH_PKEY        = 16'h666f;
  localparam logic [7:0]  BTH_RSVD        = 8'h05;

  typedef enum logic {
    RESP_READ,
    RESP_ACK
  } resp_kind_t;

  typedef struct packed {
    mac_addr_t  src_mac;
    ipv4_addr_t src_ip;
  } station_cfg_t;

  typedef struct packed {
    mac_addr_t  dst_mac;
    ipv4_addr_t dst_ip;
  } qp_cfg_t;

  typedef qp_cfg_t [NUM_QP-1:0] qp_table_t; // entry 0 is qp 3

  typedef struct packed {
    axis_data_t tdata;
    logic       tvalid;
    logic       tlast;
  } req_beat_t;

  typedef struct packed {
    axis_data_t tdata;
    axis_keep_t tkeep;
    logic       tvalid;
    logic       tlast;
  } tx_beat_t;

  typedef struct packed {
    psn_t psn;
    qpn_t qpn;
  } resp_desc_t;

endpackage

`default_nettype wire

/* rtl/req_desc_capture.sv */
`default_nettype none

module req_desc_capture (
  input  wire                       core_clk,
  input  wire                       core_aresetn,
  input  wire                       arm_i,
  input  wire rrack_pkg::req_beat_t req_i,
  output rrack_pkg::resp_desc_t     desc_o,
  output logic                      desc_valid_o
);

  logic got_first;
  logic seen_last; // stream ignored after tlast until rearmed
  logic take_beat;

  assign take_beat = arm_i && req_i.tvalid && !seen_last;

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      got_first    <= 1'b0;
      seen_last    <= 1'b0;
      desc_valid_o <= 1'b0;
    end else begin
      desc_valid_o <= 1'b0;
      if (!arm_i) begin
        got_first <= 1'b0;
        seen_last <= 1'b0;
      end else if (take_beat) begin
        got_first <= 1'b1;
        if (req_i.tlast) begin
          seen_last    <= 1'b1;
          desc_valid_o <= 1'b1;
        end
      end
    end
  end

  // fields sit msb first on the stream
  always_ff @(posedge core_clk) begin
    if (take_beat && !got_first) begin
      desc_o.psn <= {req_i.tdata[rrack_pkg::REQ_PSN_BYTE*8 +: 8],
                     req_i.tdata[(rrack_pkg::REQ_PSN_BYTE+1)*8 +: 8],
                     req_i.tdata[(rrack_pkg::REQ_PSN_BYTE+2)*8 +: 8]};
      desc_o.qpn <= {req_i.tdata[rrack_pkg::REQ_QPN_BYTE*8 +: 8],
                     req_i.tdata[(rrack_pkg::REQ_QPN_BYTE+1)*8 +: 8],
                     req_i.tdata[(rrack_pkg::REQ_QPN_BYTE+2)*8 +: 8]};
    end
  end

endmodule

`default_nettype wire

/* rtl/roce_hdr_builder.sv */
`default_nettype none

module roce_hdr_builder (
  input  wire                          core_clk,
  input  wire                          core_aresetn,
  input  wire                          load_i,
  input  wire rrack_pkg::resp_kind_t   kind_i,
  input  wire rrack_pkg::resp_desc_t   desc_i,
  input  wire rrack_pkg::station_cfg_t station_cfg_i,
  input  wire rrack_pkg::qp_table_t    qp_cfg_i,
  output rrack_pkg::roce_hdr_t         hdr_o,
  output logic                         hdr_valid_o
);

  rrack_pkg::qpn_t                       qp_off;
  logic [rrack_pkg::QP_IDX_W-1:0]        qp_idx;
  rrack_pkg::qp_cfg_t                    qp_sel;
  logic [15:0]                           tot_len;
  logic [15:0]                           udp_len;
  logic [7:0]                            opcode;
  logic [rrack_pkg::IP_HDR_BYTES*8-1:0]  ip_words; // checksum field zero
  logic [15:0]                           ip_csum;
  rrack_pkg::roce_hdr_t                  hdr_be;   // byte 0 in the msbs

  // ones complement sum of the ipv4 header words
  function automatic logic [15:0] ipv4_csum(
    input logic [rrack_pkg::IP_HDR_BYTES*8-1:0] words
  );
    logic [19:0] acc;
    logic [16:0] fold;
    acc = '0;
    for (int i = 0; i < rrack_pkg::IP_HDR_BYTES / 2; i++) begin
      acc = acc + 20'(words[i*16 +: 16]);
    end
    fold = 17'(acc[15:0]) + 17'(acc[19:16]);
    return ~(fold[15:0] + 16'(fold[16]));
  endfunction

  function automatic rrack_pkg::roce_hdr_t wire_order(input rrack_pkg::roce_hdr_t be);
    rrack_pkg::roce_hdr_t le;
    for (int i = 0; i < rrack_pkg::HDR_BYTES; i++) begin
      le[i*8 +: 8] = be[(rrack_pkg::HDR_BYTES-1-i)*8 +: 8];
    end
    return le;
  endfunction

  always_comb begin
    qp_off = desc_i.qpn - rrack_pkg::FIRST_QP;
    // unknown qp falls back to entry 0
    qp_idx = (qp_off < rrack_pkg::qpn_t'(rrack_pkg::NUM_QP)) ?
             qp_off[rrack_pkg::QP_IDX_W-1:0] : '0;
    qp_sel = qp_cfg_i[qp_idx];

    if (kind_i == rrack_pkg::RESP_READ) begin
      tot_len = rrack_pkg::IP_TOT_LEN_RD;
      opcode  = rrack_pkg::OPC_RD_RESP;
    end else begin
      tot_len = rrack_pkg::IP_TOT_LEN_ACK;
      opcode  = rrack_pkg::OPC_ACK;
    end
    udp_len = tot_len - 16'(rrack_pkg::IP_HDR_BYTES);

    ip_words = {rrack_pkg::IP_VER_IHL, rrack_pkg::IP_TOS, tot_len,
                rrack_pkg::IP_ID, rrack_pkg::IP_FLAGS,
                rrack_pkg::IP_TTL, rrack_pkg::IP_PROTO_UDP, 16'h0000,
                station_cfg_i.src_ip, qp_sel.dst_ip};
    ip_csum  = ipv4_csum(ip_words);

    hdr_be = {qp_sel.dst_mac, station_cfg_i.src_mac, rrack_pkg::ETH_TYPE_IPV4,
              ip_words[159:80], ip_csum, ip_words[63:0],
              rrack_pkg::UDP_SRC_PORT, rrack_pkg::UDP_DST_PORT, udp_len,
              16'h0000,                                  // udp checksum unused
              opcode, rrack_pkg::BTH_FLAGS, rrack_pkg::BTH_PKEY,
              rrack_pkg::BTH_RSVD, desc_i.qpn, 8'h00, desc_i.psn,
              32'h0000_0000};                            // aeth with msn 0
  end

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      hdr_valid_o <= 1'b0;
    end else begin
      hdr_valid_o <= load_i;
    end
  end

  always_ff @(posedge core_clk) begin
    if (load_i) begin
      hdr_o <= wire_order(hdr_be);
    end
  end

endmodule

`default_nettype wire

/* rtl/beat_serializer.sv */
`default_nettype none

module beat_serializer (
  input  wire                        core_clk,
  input  wire                        core_aresetn,
  input  wire                        start_i,
  input  wire rrack_pkg::resp_kind_t kind_i,
  input  wire [3:0]                  resp_idx_i,
  input  wire rrack_pkg::roce_hdr_t  hdr_i,
  output rrack_pkg::tx_beat_t        tx_o,
  output logic                       pkt_done_o
);

  logic                                   busy_q;
  rrack_pkg::pkt_len_t                    rem_q;
  logic [2:0]                             beat_q;
  logic [7:0]                             pay_q;
  rrack_pkg::pkt_len_t                    cur_len;
  logic [2:0]                             cur_beat;
  logic [7:0]                             cur_pay;
  logic                                   active;
  logic                                   last_beat;
  logic [rrack_pkg::PKT_IMG_BYTES*8-1:0]  pkt_img;
  rrack_pkg::axis_data_t                  tdata_q;
  rrack_pkg::axis_keep_t                  tkeep_q;
  logic                                   tvalid_q;
  logic                                   tlast_q;

  // start loads beat 0 on the same edge
  always_comb begin
    if (start_i) begin
      cur_len  = (kind_i == rrack_pkg::RESP_READ) ? rrack_pkg::RD_RESP_LEN : rrack_pkg::ACK_LEN;
      cur_beat = '0;
      cur_pay  = (kind_i == rrack_pkg::RESP_READ) ? {4'h1, resp_idx_i + 4'd1} : 8'h00;
    end else begin
      cur_len  = rem_q;
      cur_beat = beat_q;
      cur_pay  = pay_q;
    end
  end

  assign active    = start_i || busy_q;
  assign last_beat = (cur_len <= rrack_pkg::pkt_len_t'(rrack_pkg::AXIS_KEEP_W));
  assign pkt_img   = {{(rrack_pkg::PKT_IMG_BYTES - rrack_pkg::RD_RESP_PAYLOAD_BYTES
                        - rrack_pkg::HDR_BYTES){8'h00}},
                      {rrack_pkg::RD_RESP_PAYLOAD_BYTES{cur_pay}},
                      hdr_i};

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      busy_q     <= 1'b0;
      rem_q      <= '0;
      beat_q     <= '0;
      pay_q      <= '0;
      tvalid_q   <= 1'b0;
      tlast_q    <= 1'b0;
      pkt_done_o <= 1'b0;
    end else begin
      pkt_done_o <= tvalid_q && tlast_q;
      tvalid_q   <= active;
      tlast_q    <= active && last_beat;
      pay_q      <= cur_pay;
      if (active) begin
        busy_q <= !last_beat;
        rem_q  <= last_beat ? '0 : cur_len - rrack_pkg::pkt_len_t'(rrack_pkg::AXIS_KEEP_W);
        beat_q <= cur_beat + 3'd1;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (active) begin
      tdata_q <= pkt_img[cur_beat*rrack_pkg::AXIS_DATA_W +: rrack_pkg::AXIS_DATA_W];
      tkeep_q <= last_beat ? ({rrack_pkg::AXIS_KEEP_W{1'b1}} >> (9'd64 - cur_len))
                           : {rrack_pkg::AXIS_KEEP_W{1'b1}};
    end
  end

  assign tx_o.tdata  = tdata_q;
  assign tx_o.tkeep  = tkeep_q;
  assign tx_o.tvalid = tvalid_q;
  assign tx_o.tlast  = tlast_q;

endmodule

`default_nettype wire

/* rtl/resp_sequencer.sv */
`default_nettype none

module resp_sequencer (
  input  wire                   core_clk,
  input  wire                   core_aresetn,
  input  wire                   conf_done_i,
  input  wire                   desc_valid_i,
  input  wire                   hdr_valid_i,
  input  wire                   pkt_done_i,
  output logic                  arm_o,
  output rrack_pkg::resp_kind_t kind_o,
  output logic                  start_o,
  output logic [3:0]            resp_idx_o,
  output logic                  post_rd_wqe_o,
  output logic                  post_wr_wqe_o,
  output logic                  rd_path_done_o,
  output logic                  wr_path_done_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_POST,
    ST_WAIT_DESC,
    ST_WAIT_HDR,
    ST_SEND,
    ST_GAP,
    ST_NEXT_PHASE,
    ST_DONE
  } state_t;

  state_t                state;
  rrack_pkg::resp_kind_t kind_q;
  logic [3:0]            pkt_cnt;   // packets sent in this phase
  rrack_pkg::ifg_cnt_t   gap_cnt;
  logic [3:0]            pkt_total;
  logic                  gap_last;

  assign pkt_total = (kind_q == rrack_pkg::RESP_READ) ? 4'(rrack_pkg::NUM_RD_RESP)
                                                      : 4'(rrack_pkg::NUM_WR_ACK);
  assign gap_last  = (gap_cnt == rrack_pkg::ifg_cnt_t'(rrack_pkg::IFG_CYCLES - 1));

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      state          <= ST_IDLE;
      kind_q         <= rrack_pkg::RESP_READ;
      pkt_cnt        <= '0;
      gap_cnt        <= '0;
      rd_path_done_o <= 1'b0;
      wr_path_done_o <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (conf_done_i) begin
            state <= ST_POST;
          end
        end
        ST_POST: state <= ST_WAIT_DESC; // one cycle wqe pulse
        ST_WAIT_DESC: begin
          if (desc_valid_i) begin
            state <= ST_WAIT_HDR;
          end
        end
        ST_WAIT_HDR: begin
          if (hdr_valid_i) begin
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          if (pkt_done_i) begin
            pkt_cnt <= pkt_cnt + 4'd1;
            gap_cnt <= '0;
            state   <= ST_GAP;
          end
        end
        ST_GAP: begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_last) begin
            if (pkt_cnt != pkt_total) begin
              state <= ST_IDLE;
            end else if (kind_q == rrack_pkg::RESP_READ) begin
              rd_path_done_o <= 1'b1;
              state          <= ST_NEXT_PHASE;
            end else begin
              wr_path_done_o <= 1'b1;
              state          <= ST_DONE;
            end
          end
        end
        ST_NEXT_PHASE: begin
          kind_q  <= rrack_pkg::RESP_ACK; // write phase answers with acks
          pkt_cnt <= '0;
          state   <= ST_IDLE;
        end
        ST_DONE: state <= ST_DONE; // parked until reset
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign arm_o         = (state == ST_POST) || (state == ST_WAIT_DESC);
  assign start_o       = (state == ST_WAIT_HDR) && hdr_valid_i;
  assign post_rd_wqe_o = (state == ST_POST) && (kind_q == rrack_pkg::RESP_READ);
  assign post_wr_wqe_o = (state == ST_POST) && (kind_q == rrack_pkg::RESP_ACK);
  assign kind_o        = kind_q;
  assign resp_idx_o    = pkt_cnt;

endmodule

`default_nettype wire

/* rtl/rdma_resp_gen_top.sv */
`default_nettype none

module rdma_resp_gen_top (
  input  wire                          core_clk,
  input  wire                          core_aresetn,
  input  wire                          conf_done_i,
  input  wire rrack_pkg::station_cfg_t station_cfg_i,
  input  wire rrack_pkg::qp_table_t    qp_cfg_i,
  input  wire rrack_pkg::req_beat_t    req_i,
  output rrack_pkg::tx_beat_t          tx_o,
  output logic                         post_rd_wqe_o,
  output logic                         post_wr_wqe_o,
  output logic                         rd_path_done_o,
  output logic                         wr_path_done_o
);

  logic                  arm;
  rrack_pkg::resp_desc_t desc;
  logic                  desc_valid;
  rrack_pkg::resp_kind_t kind;
  rrack_pkg::roce_hdr_t  hdr;
  logic                  hdr_valid;
  logic                  start;
  logic [3:0]            resp_idx;
  logic                  pkt_done;

  req_desc_capture u_capture (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .arm_i        (arm),
    .req_i        (req_i),
    .desc_o       (desc),
    .desc_valid_o (desc_valid)
  );

  roce_hdr_builder u_hdr (
    .core_clk      (core_clk),
    .core_aresetn  (core_aresetn),
    .load_i        (desc_valid),
    .kind_i        (kind),
    .desc_i        (desc),
    .station_cfg_i (station_cfg_i),
    .qp_cfg_i      (qp_cfg_i),
    .hdr_o         (hdr),
    .hdr_valid_o   (hdr_valid)
  );

  beat_serializer u_ser (
    .core_clk     (core_clk),
    .core_aresetn (core_aresetn),
    .start_i      (start),
    .kind_i       (kind),
    .resp_idx_i   (resp_idx),
    .hdr_i        (hdr),
    .tx_o         (tx_o),
    .pkt_done_o   (pkt_done)
  );

  resp_sequencer u_seq (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .conf_done_i    (conf_done_i),
    .desc_valid_i   (desc_valid),
    .hdr_valid_i    (hdr_valid),
    .pkt_done_i     (pkt_done),
    .arm_o          (arm),
    .kind_o         (kind),
    .start_o        (start),
    .resp_idx_o     (resp_idx),
    .post_rd_wqe_o  (post_rd_wqe_o),
    .post_wr_wqe_o  (post_wr_wqe_o),
    .rd_path_done_o (rd_path_done_o),
    .wr_path_done_o (wr_path_done_o)
  );

endmodule

`default_nettype wire

/* testbench/rdma_resp_gen_assertions.sv */
`default_nettype none

module rdma_resp_gen_assertions (
  input wire                          core_clk,
  input wire                          core_aresetn,
  input wire                          conf_done_i,
  input wire rrack_pkg::station_cfg_t station_cfg_i,
  input wire rrack_pkg::qp_table_t    qp_cfg_i,
  input wire rrack_pkg::req_beat_t    req_i,
  input wire rrack_pkg::tx_beat_t     tx_o,
  input wire                          post_rd_wqe_o,
  input wire                          post_wr_wqe_o,
  input wire                          rd_path_done_o,
  input wire                          wr_path_done_o
);
  timeunit 1ns;
  timeprecision 100ps;

  bit                    failed = 1'b0;
  int                    beat_idx;   // beat number inside the current packet
  int                    gap_cnt;    // cycles since the last tlast beat
  int                    rd_posts;
  int                    wr_posts;
  int                    last_idx;
  logic                  want_desc;
  logic [23:0]           exp_psn;
  logic [23:0]           exp_qpn;
  rrack_pkg::qp_cfg_t    exp_qp;
  logic [7:0]            exp_pay;
  int                    bad_idx;
  logic [7:0]            bad_byte;
  rrack_pkg::axis_keep_t exp_keep;

  // n wire bytes starting at first as one msb first value
  function automatic logic [47:0] field(input rrack_pkg::axis_data_t d, input int first,
                                        input int n);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[39:0], d[(first + i)*8 +: 8]};
    end
    return v;
  endfunction

  // sum over the whole ipv4 header incl. checksum
  function automatic logic [15:0] ip_sum(input rrack_pkg::axis_data_t d);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < 10; i++) begin
      acc = acc + 32'(field(d, 14 + 2*i, 2));
    end
    acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
    acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
    return acc[15:0];
  endfunction

  always_ff @(posedge core_clk or negedge core_aresetn) begin
    if (!core_aresetn) begin
      want_desc <= 1'b0;
      rd_posts  <= 0;
      wr_posts  <= 0;
      beat_idx  <= 0;
      gap_cnt   <= rrack_pkg::IFG_CYCLES;
    end else begin
      if (post_rd_wqe_o) begin
        rd_posts <= rd_posts + 1;
      end
      if (post_wr_wqe_o) begin
        wr_posts <= wr_posts + 1;
      end
      if (post_rd_wqe_o || post_wr_wqe_o) begin
        want_desc <= 1'b1;
      end else if (want_desc && req_i.tvalid) begin
        want_desc <= 1'b0; // only the first request beat carries the fields
        exp_qpn   <= 24'(field(req_i.tdata, rrack_pkg::REQ_QPN_BYTE, 3));
        exp_psn   <= 24'(field(req_i.tdata, rrack_pkg::REQ_PSN_BYTE, 3));
      end
      if (tx_o.tvalid) begin
        beat_idx <= tx_o.tlast ? 0 : beat_idx + 1;
      end
      if (tx_o.tvalid && tx_o.tlast) begin
        gap_cnt <= 0;
      end else if (gap_cnt < rrack_pkg::IFG_CYCLES) begin
        gap_cnt <= gap_cnt + 1;
      end
    end
  end

  always_comb begin
    int g;
    if (exp_qpn >= 24'd3 && exp_qpn <= 24'd7) begin
      exp_qp = qp_cfg_i[3'(exp_qpn - 24'd3)];
    end else begin
      exp_qp = qp_cfg_i[0];
    end
    last_idx = rd_path_done_o ? 0 : 4; // ack is one beat and a read response five
    exp_keep = (beat_idx == last_idx) ? {{6{1'b0}}, {58{1'b1}}} : {64{1'b1}};
    exp_pay  = {4'h1, 4'(rd_posts - 1) + 4'd1};
    bad_idx  = -1;
    bad_byte = 8'h00;
    for (int k = 0; k < 64; k++) begin
      g = beat_idx * 64 + k;
      if (bad_idx < 0 && g >= rrack_pkg::HDR_BYTES && g < int'(rrack_pkg::RD_RESP_LEN) &&
          tx_o.tdata[k*8 +: 8] != exp_pay) begin
        bad_idx  = k;
        bad_byte = tx_o.tdata[k*8 +: 8];
      end
    end
  end

  quiet_before_conf: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    !conf_done_i |-> !(tx_o.tvalid || tx_o.tlast || post_rd_wqe_o || post_wr_wqe_o ||
                       rd_path_done_o || wr_path_done_o))
    else begin
      failed = 1'b1;
      $error("output activity before conf_done_i at %0t", $time);
    end

  last_needs_valid: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tlast |-> tx_o.tvalid)
    else begin
      failed = 1'b1;
      $error("tlast without tvalid at %0t", $time);
    end

  beats_contiguous: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && !tx_o.tlast |=> tx_o.tvalid)
    else begin
      failed = 1'b1;
      $error("gap inside a packet at %0t", $time);
    end

  beat_count: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid |-> (tx_o.tlast ? beat_idx == last_idx : beat_idx < last_idx))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t tx_o.tlast at beat %0d expected last beat %0d",
             $time, $sampled(beat_idx), $sampled(last_idx));
    end

  keep_rule: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid |-> tx_o.tkeep == exp_keep)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t tx_o.tkeep got %h expected %h",
             $time, $sampled(tx_o.tkeep), $sampled(exp_keep));
    end

  ip_checksum: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> ip_sum(tx_o.tdata) == 16'hffff)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t ipv4 header sum got %h expected ffff",
             $time, ip_sum($sampled(tx_o.tdata)));
    end

  src_addr: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |->
      field(tx_o.tdata, 6, 6) == station_cfg_i.src_mac &&
      field(tx_o.tdata, 26, 4) == 48'(station_cfg_i.src_ip))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t src mac and ip got %h %h expected %h %h",
             $time, field($sampled(tx_o.tdata), 6, 6), field($sampled(tx_o.tdata), 26, 4),
             station_cfg_i.src_mac, station_cfg_i.src_ip);
    end

  dst_mac: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> field(tx_o.tdata, 0, 6) == exp_qp.dst_mac)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t dst mac got %h expected %h",
             $time, field($sampled(tx_o.tdata), 0, 6), exp_qp.dst_mac);
    end

  dst_ip: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> field(tx_o.tdata, 30, 4) == 48'(exp_qp.dst_ip))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t dst ip got %h expected %h",
             $time, field($sampled(tx_o.tdata), 30, 4), exp_qp.dst_ip);
    end

  bth_qpn: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> field(tx_o.tdata, 47, 3) == 48'(exp_qpn))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t bth qpn got %h expected %h",
             $time, field($sampled(tx_o.tdata), 47, 3), exp_qpn);
    end

  bth_psn: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> field(tx_o.tdata, 51, 3) == 48'(exp_psn))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t bth psn got %h expected %h",
             $time, field($sampled(tx_o.tdata), 51, 3), exp_psn);
    end

  bth_opcode: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |->
      tx_o.tdata[42*8 +: 8] == (rd_path_done_o ? rrack_pkg::OPC_ACK : rrack_pkg::OPC_RD_RESP))
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t bth opcode got %h in %s phase",
             $time, $sampled(tx_o.tdata[42*8 +: 8]), rd_path_done_o ? "write" : "read");
    end

  payload_bytes: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && !rd_path_done_o |-> bad_idx < 0)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t tx_o.tdata byte %0d got %h expected %h",
             $time, $sampled(bad_idx), $sampled(bad_byte), $sampled(exp_pay));
    end

  first_beat_latency: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $past(req_i.tvalid && req_i.tlast, 3) |-> tx_o.tvalid && beat_idx == 0)
    else begin
      failed = 1'b1;
      $error("no first beat 3 cycles after request at %0t", $time);
    end

  beat_has_request: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> $past(req_i.tvalid && req_i.tlast, 3))
    else begin
      failed = 1'b1;
      $error("packet not 3 cycles after request at %0t", $time);
    end

  inter_packet_gap: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    tx_o.tvalid && beat_idx == 0 |-> gap_cnt >= rrack_pkg::IFG_CYCLES)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t gap cycles got %0d expected at least %0d",
             $time, $sampled(gap_cnt), rrack_pkg::IFG_CYCLES);
    end

  rd_post_order: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_rd_wqe_o |-> !rd_path_done_o && !post_wr_wqe_o)
    else begin
      failed = 1'b1;
      $error("read wqe posted after read phase at %0t", $time);
    end

  wr_post_order: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    post_wr_wqe_o |-> rd_path_done_o && !wr_path_done_o)
    else begin
      failed = 1'b1;
      $error("write wqe posted out of phase at %0t", $time);
    end

  rd_done_count: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $rose(rd_path_done_o) |-> rd_posts == rrack_pkg::NUM_RD_RESP && wr_posts == 0)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t post_rd_wqe_o count got %0d expected %0d",
             $time, $sampled(rd_posts), rrack_pkg::NUM_RD_RESP);
    end

  wr_done_count: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    $rose(wr_path_done_o) |-> wr_posts == rrack_pkg::NUM_WR_ACK)
    else begin
      failed = 1'b1;
      $error("CHECK FAILED t=%0t post_wr_wqe_o count got %0d expected %0d",
             $time, $sampled(wr_posts), rrack_pkg::NUM_WR_ACK);
    end

  done_levels_hold: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    (rd_path_done_o |=> rd_path_done_o) and (wr_path_done_o |=> wr_path_done_o) and
    (wr_path_done_o |-> rd_path_done_o))
    else begin
      failed = 1'b1;
      $error("done level dropped or out of order at %0t", $time);
    end

  silent_after_done: assert property (@(posedge core_clk) disable iff (!core_aresetn)
    wr_path_done_o |-> !(tx_o.tvalid || post_rd_wqe_o || post_wr_wqe_o))
    else begin
      failed = 1'b1;
      $error("activity after wr_path_done_o at %0t", $time);
    end

endmodule

`default_nettype wire

/* testbench/tb_rdma_resp_gen.sv */
`default_nettype none

module tb_rdma_resp_gen;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 10;
  localparam int NUM_PKTS   = rrack_pkg::NUM_RD_RESP + rrack_pkg::NUM_WR_ACK;
  localparam int MAX_CYCLES = 6000; // 16 packets of about 270 cycles plus margin

  logic                    core_clk = 1'b0;
  logic                    core_aresetn;
  logic                    conf_done;
  rrack_pkg::station_cfg_t station_cfg;
  rrack_pkg::qp_table_t    qp_cfg;
  rrack_pkg::req_beat_t    req;
  rrack_pkg::tx_beat_t     tx;
  logic                    post_rd_wqe;
  logic                    post_wr_wqe;
  logic                    rd_path_done;
  logic                    wr_path_done;
  logic [31:0]             lfsr = 32'hf265_4b50;
  int                      cycle_cnt = 0;

  rdma_resp_gen_top dut0 (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .conf_done_i    (conf_done),
    .station_cfg_i  (station_cfg),
    .qp_cfg_i       (qp_cfg),
    .req_i          (req),
    .tx_o           (tx),
    .post_rd_wqe_o  (post_rd_wqe),
    .post_wr_wqe_o  (post_wr_wqe),
    .rd_path_done_o (rd_path_done),
    .wr_path_done_o (wr_path_done)
  );

  bind rdma_resp_gen_top rdma_resp_gen_assertions chk0 (
    .core_clk       (core_clk),
    .core_aresetn   (core_aresetn),
    .conf_done_i    (conf_done_i),
    .station_cfg_i  (station_cfg_i),
    .qp_cfg_i       (qp_cfg_i),
    .req_i          (req_i),
    .tx_o           (tx_o),
    .post_rd_wqe_o  (post_rd_wqe_o),
    .post_wr_wqe_o  (post_wr_wqe_o),
    .rd_path_done_o (rd_path_done_o),
    .wr_path_done_o (wr_path_done_o)
  );

  always #(CLK_PERIOD / 2) core_clk = ~core_clk;

  always @(posedge core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // two beat request with the fields msb first in beat 0
  task automatic send_request(input logic [23:0] qpn, input logic [23:0] psn);
    rrack_pkg::axis_data_t data;
    for (int i = 0; i < 64; i++) begin
      data[i*8 +: 8] = 8'(i);
    end
    data[rrack_pkg::REQ_QPN_BYTE*8 +: 24] = {qpn[7:0], qpn[15:8], qpn[23:16]};
    data[rrack_pkg::REQ_PSN_BYTE*8 +: 24] = {psn[7:0], psn[15:8], psn[23:16]};
    req.tdata  = data;
    req.tvalid = 1'b1;
    req.tlast  = 1'b0;
    @(negedge core_clk);
    req.tdata = ~data; // must not replace the captured fields
    req.tlast = 1'b1;
    @(negedge core_clk);
    req = '0;
  endtask

  task automatic answer_post();
    logic [31:0] bits;
    logic [23:0] qpn;
    logic [23:0] psn;
    do begin
      @(negedge core_clk);
    end while (!(post_rd_wqe || post_wr_wqe));
    draw_bits(2, bits);
    repeat (1 + int'(bits[1:0])) @(negedge core_clk);
    draw_bits(3, bits);
    qpn = rrack_pkg::FIRST_QP + 24'(bits % 32'd5);
    draw_bits(24, bits);
    psn = bits[23:0];
    send_request(qpn, psn);
  endtask

  initial begin
    core_aresetn = 1'b0;
    conf_done    = 1'b0;
    req          = '0;
    station_cfg  = {48'h02_aa_bb_cc_dd_01, 32'hc0a8_0a01};
    for (int i = 0; i < rrack_pkg::NUM_QP; i++) begin
      qp_cfg[i] = {40'h02_11_22_33_44, 8'(16 + i), 24'hc0a80a, 8'(20 + i)};
    end
    repeat (RST_CYCLES) @(posedge core_clk);
    @(negedge core_clk);
    core_aresetn = 1'b1;
    repeat (20) @(negedge core_clk); // idle window before configuration
    conf_done = 1'b1;
    repeat (NUM_PKTS) answer_post();
    wait (wr_path_done);
    repeat (rrack_pkg::IFG_CYCLES + 20) @(negedge core_clk);
    if (dut0.chk0.failed) begin
      $display("an assertion failed during the run");
      $display("Finished with errors");
      $fatal(1, "run failed");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  initial begin
    wait (dut0.chk0.failed || cycle_cnt >= MAX_CYCLES);
    if (dut0.chk0.failed) begin
      $display("stopping at the first failed assertion");
    end else begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    end
    $display("Finished with errors");
    $fatal(1, "run aborted");
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/rrack_pkg.sv
rtl/req_desc_capture.sv
rtl/roce_hdr_builder.sv
rtl/beat_serializer.sv
rtl/resp_sequencer.sv
rtl/rdma_resp_gen_top.sv
testbench/rdma_resp_gen_assertions.sv
testbench/tb_rdma_resp_gen.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rdma_resp_gen
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

FAIL_MSG := Finished with errors
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation FAILED: no final message in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
